//--- mipsCore.f
logic/mipsIsaPkg.sv
logic/mipsCorePkg.sv
logic/regFileIf.sv
logic/controlUnit.sv
logic/alu.sv
logic/registerFile.sv
logic/fetchUnit.sv
logic/dataMemory.sv
logic/mipsCore.sv
verification/mipsCoreTb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module mipsCoreTb -f mipsCore.f -o mipsCoreSim

./obj_dir/mipsCoreSim > sim.log
cat sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without a reported failure"

//--- verification/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;

	localparam int IMEM_WORDS     = 256;
	localparam int DMEM_WORDS     = 256;
	localparam int LOOP_IDX       = 100; // word index of the closing self-loop
	localparam int RETIRE_TIMEOUT = 200;

	typedef struct packed {
		mipsCorePkg::wordT    pc;
		logic                 regWrite;
		mipsCorePkg::regAddrT regNum;
		mipsCorePkg::wordT    data;
		logic                 store;
		mipsCorePkg::wordT    storeAddr;
		mipsCorePkg::wordT    storeData;
	} retireRecT;

	logic clk;
	logic rst;
	logic loadEn;
	mipsCorePkg::wordT loadAddr;
	mipsCorePkg::wordT loadData;
	logic run;
	logic retireValid;
	logic retireReady;
	mipsCorePkg::wordT retirePc;
	logic retireRegWrite;
	mipsCorePkg::regAddrT retireReg;
	mipsCorePkg::wordT retireData;
	logic retireStore;
	mipsCorePkg::wordT retireStoreAddr;
	mipsCorePkg::wordT retireStoreData;

	int seed = 54;
	mipsCorePkg::wordT prog [IMEM_WORDS];
	logic landed [IMEM_WORDS]; // slots some forward jump lands on
	mipsCorePkg::wordT mPc;
	mipsCorePkg::wordT mRegs [32];
	mipsCorePkg::wordT mMem [DMEM_WORDS];
	retireRecT expQ [$];
	retireRecT expRec;
	int expCount;
	int gotCount;
	int pcErrors;
	int regErrors;
	int storeErrors;
	int timeoutErrors;

	mipsCore #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) mipsCore_i (
		.clk             (clk),
		.rst             (rst),
		.loadEn          (loadEn),
		.loadAddr        (loadAddr),
		.loadData        (loadData),
		.run             (run),
		.retireValid     (retireValid),
		.retireReady     (retireReady),
		.retirePc        (retirePc),
		.retireRegWrite  (retireRegWrite),
		.retireReg       (retireReg),
		.retireData      (retireData),
		.retireStore     (retireStore),
		.retireStoreAddr (retireStoreAddr),
		.retireStoreData (retireStoreData)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int randBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic mipsCorePkg::regAddrT randReg();
		return mipsCorePkg::regAddrT'(randBelow(8));
	endfunction

	function automatic logic [15:0] smallImm();
		return 16'(randBelow(128) - 64); // -64 .. 63
	endfunction

	function automatic mipsIsaPkg::functT pickFunct();
		case (randBelow(5))
			0: return mipsIsaPkg::FN_ADD;
			1: return mipsIsaPkg::FN_SUB;
			2: return mipsIsaPkg::FN_AND;
			3: return mipsIsaPkg::FN_OR;
			default: return mipsIsaPkg::FN_SLT;
		endcase
	endfunction

	function automatic mipsCorePkg::wordT encR(input mipsCorePkg::regAddrT rs,
			input mipsCorePkg::regAddrT rt, input mipsCorePkg::regAddrT rd,
			input mipsIsaPkg::functT fn);
		return {mipsIsaPkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mipsCorePkg::wordT encI(input mipsIsaPkg::opcodeT op,
			input mipsCorePkg::regAddrT rs, input mipsCorePkg::regAddrT rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mipsCorePkg::wordT encJ(input mipsIsaPkg::opcodeT op, input int idx);
		return {op, 26'(idx)}; // target26 is the word index
	endfunction

	task automatic buildProgram();
		int i;
		int kind;
		int room;
		int k;
		mipsCorePkg::regAddrT rx;
		for (int w = 0; w < IMEM_WORDS; w++)
		begin
			prog[w]   = encJ(mipsIsaPkg::OP_J, w); // every spare word spins on itself
			landed[w] = 1'b0;
		end
		i = 0;
		while (i < LOOP_IDX)
		begin
			kind = randBelow(15);
			room = LOOP_IDX - i - 1;
			case (kind)
				0, 1, 2, 3: prog[i] = encR(randReg(), randReg(), randReg(), pickFunct());
				4: prog[i] = encI(mipsIsaPkg::OP_ADDI, randReg(), randReg(), smallImm());
				5: prog[i] = encI(mipsIsaPkg::OP_ANDI, randReg(), randReg(), 16'($random(seed)));
				6: prog[i] = encI(mipsIsaPkg::OP_ORI, randReg(), randReg(), 16'($random(seed)));
				7: prog[i] = encI(mipsIsaPkg::OP_SLTI, randReg(), randReg(), smallImm());
				8: prog[i] = encI(mipsIsaPkg::OP_SW, 5'd0, randReg(), 16'(4 * randBelow(8)));
				9: prog[i] = encI(mipsIsaPkg::OP_LW, 5'd0, randReg(), 16'(4 * randBelow(8)));
				10, 11:
				begin
					k = i + 1 + randBelow((room < 3 ? room : 3) + 1); // forward only
					landed[k] = 1'b1;
					prog[i] = encI(kind == 10 ? mipsIsaPkg::OP_BEQ : mipsIsaPkg::OP_BNE,
						randReg(), randReg(), 16'(k - i - 1));
				end
				12, 13:
				begin
					k = i + 1 + randBelow((room < 3 ? room : 3) + 1);
					landed[k] = 1'b1;
					prog[i] = encJ(kind == 12 ? mipsIsaPkg::OP_J : mipsIsaPkg::OP_JAL, k);
				end
				default:
				begin
					// ori then jr, only if nothing can jump straight onto the jr
					if (room >= 1 && !landed[i + 1])
					begin
						rx = mipsCorePkg::regAddrT'(1 + randBelow(7));
						k = i + 2 + randBelow(room);
						landed[k] = 1'b1;
						prog[i] = encI(mipsIsaPkg::OP_ORI, 5'd0, rx, 16'(4 * k));
						i++;
						prog[i] = encR(rx, 5'd0, 5'd0, mipsIsaPkg::FN_JR);
					end
					else
						prog[i] = encR(randReg(), randReg(), randReg(), mipsIsaPkg::FN_ADD);
				end
			endcase
			i++;
		end
	endtask

	// architectural model, one instruction per call
	function automatic retireRecT stepModel();
		mipsCorePkg::wordT ins;
		mipsIsaPkg::opcodeT op;
		mipsIsaPkg::functT fn;
		mipsCorePkg::regAddrT rs;
		mipsCorePkg::regAddrT rt;
		mipsCorePkg::regAddrT rd;
		mipsCorePkg::wordT sImm;
		mipsCorePkg::wordT zImm;
		mipsCorePkg::wordT a;
		mipsCorePkg::wordT b;
		mipsCorePkg::wordT pc4;
		mipsCorePkg::wordT nextPc;
		logic wrEn;
		mipsCorePkg::regAddrT wrNum;
		mipsCorePkg::wordT wrVal;
		retireRecT rec;
		ins  = prog[int'((mPc >> 2) % IMEM_WORDS)];
		op   = ins[31:26];
		rs   = ins[25:21];
		rt   = ins[20:16];
		rd   = ins[15:11];
		fn   = ins[5:0];
		sImm = {{16{ins[15]}}, ins[15:0]};
		zImm = {16'h0000, ins[15:0]};
		a    = mRegs[rs];
		b    = mRegs[rt];
		pc4  = mPc + 32'd4;
		nextPc = pc4;
		wrEn  = 1'b0;
		wrNum = rt;
		wrVal = '0;
		rec   = '0;
		rec.pc = mPc;
		case (op)
			mipsIsaPkg::OP_RTYPE:
			begin
				wrEn  = 1'b1;
				wrNum = rd;
				case (fn)
					mipsIsaPkg::FN_ADD: wrVal = a + b;
					mipsIsaPkg::FN_SUB: wrVal = a - b;
					mipsIsaPkg::FN_AND: wrVal = a & b;
					mipsIsaPkg::FN_OR:  wrVal = a | b;
					mipsIsaPkg::FN_SLT: wrVal = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:
					begin
						wrEn   = 1'b0; // jr
						nextPc = a;
					end
				endcase
			end
			mipsIsaPkg::OP_ADDI: {wrEn, wrVal} = {1'b1, a + sImm};
			mipsIsaPkg::OP_ANDI: {wrEn, wrVal} = {1'b1, a & zImm};
			mipsIsaPkg::OP_ORI:  {wrEn, wrVal} = {1'b1, a | zImm};
			mipsIsaPkg::OP_SLTI:
				{wrEn, wrVal} = {1'b1, ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0};
			mipsIsaPkg::OP_LW: {wrEn, wrVal} = {1'b1, mMem[int'(((a + sImm) >> 2) % DMEM_WORDS)]};
			mipsIsaPkg::OP_SW:
			begin
				rec.store     = 1'b1;
				rec.storeAddr = a + sImm;
				rec.storeData = b;
				mMem[int'(((a + sImm) >> 2) % DMEM_WORDS)] = b;
			end
			mipsIsaPkg::OP_BEQ: nextPc = (a == b) ? pc4 + (sImm << 2) : pc4;
			mipsIsaPkg::OP_BNE: nextPc = (a != b) ? pc4 + (sImm << 2) : pc4;
			mipsIsaPkg::OP_J:   nextPc = {pc4[31:28], ins[25:0], 2'b00};
			default:
			begin
				nextPc = {pc4[31:28], ins[25:0], 2'b00}; // jal links into r31
				{wrEn, wrNum, wrVal} = {1'b1, 5'd31, pc4};
			end
		endcase
		if (wrEn && wrNum != 5'd0)
		begin
			mRegs[wrNum] = wrVal;
			rec.regWrite = 1'b1;
			rec.regNum   = wrNum;
			rec.data     = wrVal;
		end
		mPc = nextPc;
		return rec;
	endfunction

	task automatic buildExpected();
		int loops;
		mPc = '0;
		for (int r = 0; r < 32; r++)
			mRegs[r] = '0;
		for (int w = 0; w < DMEM_WORDS; w++)
			mMem[w] = '0;
		loops = 0;
		while (loops < 3 && expQ.size() < 1000)
		begin
			if (mPc == 32'(4 * LOOP_IDX))
				loops++; // follow the self-loop three times only
			expQ.push_back(stepModel());
		end
		expCount = expQ.size();
	endtask

	task automatic checkPc(input mipsCorePkg::wordT got, input mipsCorePkg::wordT exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: retirePc %h, expected %h", $time, got, exp);
			pcErrors++;
		end
	endtask

	task automatic checkRegWrite(input mipsCorePkg::wordT pc, input logic gotEn,
			input mipsCorePkg::regAddrT gotReg, input mipsCorePkg::wordT gotData,
			input logic expEn, input mipsCorePkg::regAddrT expReg,
			input mipsCorePkg::wordT expData);
		if (gotEn !== expEn || (expEn && (gotReg !== expReg || gotData !== expData)))
		begin
			$display("CHECK FAILED at %0t: pc %h write %b r%0d=%h, expected %b r%0d=%h",
				$time, pc, gotEn, gotReg, gotData, expEn, expReg, expData);
			regErrors++;
		end
	endtask

	task automatic checkStore(input mipsCorePkg::wordT pc, input logic gotEn,
			input mipsCorePkg::wordT gotAddr, input mipsCorePkg::wordT gotData,
			input logic expEn, input mipsCorePkg::wordT expAddr,
			input mipsCorePkg::wordT expData);
		if (gotEn !== expEn || (expEn && (gotAddr !== expAddr || gotData !== expData)))
		begin
			$display("CHECK FAILED at %0t: pc %h store %b [%h]=%h, expected %b [%h]=%h",
				$time, pc, gotEn, gotAddr, gotData, expEn, expAddr, expData);
			storeErrors++;
		end
	endtask

	// one record per transfer edge, in program order
	always @(posedge clk)
	begin
		if (!rst && retireValid && retireReady && expQ.size() > 0)
		begin
			expRec = expQ.pop_front();
			checkPc(retirePc, expRec.pc);
			checkRegWrite(expRec.pc, retireRegWrite, retireReg, retireData,
				expRec.regWrite, expRec.regNum, expRec.data);
			checkStore(expRec.pc, retireStore, retireStoreAddr, retireStoreData,
				expRec.store, expRec.storeAddr, expRec.storeData);
			gotCount++;
		end
	end

	// random back-pressure, about one cycle in four
	always @(negedge clk)
		retireReady = (randBelow(4) != 0);

	task automatic waitForRetirements();
		int idle;
		int lastCount;
		idle = 0;
		lastCount = gotCount;
		while (gotCount < expCount)
		begin
			@(negedge clk);
			if (gotCount != lastCount)
			begin
				lastCount = gotCount;
				idle = 0;
			end
			else
				idle++;
			if (idle > RETIRE_TIMEOUT)
			begin
				$display("timeout: no retirement arrived for %0d cycles after %0d of %0d records",
					RETIRE_TIMEOUT, gotCount, expCount);
				timeoutErrors++;
				return;
			end
		end
	endtask

	initial
	begin
		rst = 1'b1;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		run = 1'b0;
		retireReady = 1'b0;
		gotCount = 0;
		pcErrors = 0;
		regErrors = 0;
		storeErrors = 0;
		timeoutErrors = 0;
		buildProgram();
		buildExpected();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int w = 0; w < IMEM_WORDS; w++)
		begin
			loadEn   = 1'b1;
			loadAddr = mipsCorePkg::wordT'(w);
			loadData = prog[w];
			@(negedge clk);
		end
		loadEn = 1'b0;
		run = 1'b1;
		waitForRetirements();
		run = 1'b0;
		@(negedge clk);
		$display("errors: pc %0d, register write %0d, store %0d, timeout %0d (%0d of %0d records)",
			pcErrors, regErrors, storeErrors, timeoutErrors, gotCount, expCount);
		if (pcErrors + regErrors + storeErrors + timeoutErrors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- logic/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 loadEn,
	input  mipsCorePkg::wordT    loadAddr,
	input  mipsCorePkg::wordT    loadData,
	input  logic                 run,
	output logic                 retireValid,
	input  logic                 retireReady,
	output mipsCorePkg::wordT    retirePc,
	output logic                 retireRegWrite,
	output mipsCorePkg::regAddrT retireReg,
	output mipsCorePkg::wordT    retireData,
	output logic                 retireStore,
	output mipsCorePkg::wordT    retireStoreAddr,
	output mipsCorePkg::wordT    retireStoreData
);

	mipsCorePkg::wordT     pc;
	mipsCorePkg::wordT     pcPlus4;
	mipsCorePkg::wordT     instr;
	mipsCorePkg::ctrlWordT ctrl;
	mipsCorePkg::regAddrT  rsNum;
	mipsCorePkg::regAddrT  rtNum;
	mipsCorePkg::regAddrT  rdNum;
	mipsCorePkg::regAddrT  destReg;
	logic [15:0]           imm16;
	mipsCorePkg::wordT     immSext;
	mipsCorePkg::wordT     immExt;
	mipsCorePkg::wordT     aluB;
	mipsCorePkg::wordT     aluResult;
	logic                  aluCond;
	mipsCorePkg::wordT     memRdData;
	mipsCorePkg::wordT     wbData;
	logic                  advance;

	regFileIf rf ();

	// freeze everything while a record waits on the retire port
	assign advance = run && !loadEn && (!retireValid || retireReady);

	assign rsNum = instr[mipsIsaPkg::RS_MSB:mipsIsaPkg::RS_LSB];
	assign rtNum = instr[mipsIsaPkg::RT_MSB:mipsIsaPkg::RT_LSB];
	assign rdNum = instr[mipsIsaPkg::RD_MSB:mipsIsaPkg::RD_LSB];
	assign imm16 = instr[mipsIsaPkg::IMM_MSB:mipsIsaPkg::IMM_LSB];

	assign immSext = {{16{imm16[15]}}, imm16};
	assign immExt  = ctrl.zeroExt ? {16'h0000, imm16} : immSext;
	assign aluB    = ctrl.aluSrc ? immExt : rf.rtData;

	always_comb
	begin
		case (ctrl.regDst)
			mipsCorePkg::RD_RD: destReg = rdNum;
			mipsCorePkg::RD_RA: destReg = 5'd31;
			default:            destReg = rtNum;
		endcase
		case (ctrl.memToReg)
			mipsCorePkg::WB_MEM: wbData = memRdData;
			mipsCorePkg::WB_PC4: wbData = pcPlus4; // jal link value
			default:             wbData = aluResult;
		endcase
	end

	assign rf.rsAddr = rsNum;
	assign rf.rtAddr = rtNum;
	assign rf.wrEn   = advance && ctrl.regWrite;
	assign rf.wrAddr = destReg;
	assign rf.wrData = wbData;

	fetchUnit #(.IMEM_WORDS(IMEM_WORDS)) fetchUnit_i (
		.clk        (clk),
		.rst        (rst),
		.loadEn     (loadEn),
		.loadAddr   (loadAddr),
		.loadData   (loadData),
		.advance    (advance),
		.jump       (ctrl.jump),
		.takeBranch (ctrl.branch && aluCond),
		.target26   (instr[mipsIsaPkg::TGT_MSB:mipsIsaPkg::TGT_LSB]),
		.immExt     (immSext),
		.rsValue    (rf.rsData),
		.pc         (pc),
		.pcPlus4    (pcPlus4),
		.instr      (instr)
	);

	controlUnit controlUnit_i (
		.opcode (instr[mipsIsaPkg::OP_MSB:mipsIsaPkg::OP_LSB]),
		.funct  (instr[mipsIsaPkg::FN_MSB:mipsIsaPkg::FN_LSB]),
		.ctrl   (ctrl)
	);

	alu alu_i (
		.aluOp  (ctrl.aluOp),
		.funct  (instr[mipsIsaPkg::FN_MSB:mipsIsaPkg::FN_LSB]),
		.a      (rf.rsData),
		.b      (aluB),
		.result (aluResult),
		.cond   (aluCond)
	);

	registerFile registerFile_i (
		.clk (clk),
		.rst (rst),
		.rf  (rf.regs)
	);

	dataMemory #(.DMEM_WORDS(DMEM_WORDS)) dataMemory_i (
		.clk    (clk),
		.rst    (rst),
		.wrEn   (advance && ctrl.memWrite),
		.addr   (aluResult),
		.wrData (rf.rtData),
		.rdData (memRdData)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
			retireValid <= 1'b0;
		else if (advance)
			retireValid <= 1'b1;
		else if (retireReady)
			retireValid <= 1'b0;
	end

	// record payload only moves on advance
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			retirePc        <= pc;
			retireRegWrite  <= ctrl.regWrite && (destReg != '0); // r0 target reports no write
			retireReg       <= destReg;
			retireData      <= wbData;
			retireStore     <= ctrl.memWrite;
			retireStoreAddr <= aluResult;
			retireStoreData <= rf.rtData;
		end
	end

endmodule

//--- logic/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
	parameter int DMEM_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              wrEn,
	input  mipsCorePkg::wordT addr,
	input  mipsCorePkg::wordT wrData,
	output mipsCorePkg::wordT rdData
);

	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	mipsCorePkg::wordT  mem [DMEM_WORDS];
	logic [DMEM_AW-1:0] idx;

	// byte address, low two bits ignored and wraps at the top
	assign idx    = DMEM_AW'((addr >> 2) % DMEM_WORDS);
	assign rdData = mem[idx];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				mem[i] <= '0;
		end
		else if (wrEn)
		begin
			mem[idx] <= wrData;
		end
	end

endmodule

//--- logic/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
	parameter int IMEM_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              loadEn,
	input  mipsCorePkg::wordT loadAddr, // word index, not byte address
	input  mipsCorePkg::wordT loadData,
	input  logic              advance,
	input  mipsCorePkg::jumpT jump,
	input  logic              takeBranch,
	input  logic [25:0]       target26,
	input  mipsCorePkg::wordT immExt,
	input  mipsCorePkg::wordT rsValue,
	output mipsCorePkg::wordT pc,
	output mipsCorePkg::wordT pcPlus4,
	output mipsCorePkg::wordT instr
);

	localparam int IMEM_AW = $clog2(IMEM_WORDS);

	mipsCorePkg::wordT   imem [IMEM_WORDS];
	logic [IMEM_AW-1:0]  pcIdx;
	logic [IMEM_AW-1:0]  loadIdx;
	mipsCorePkg::wordT   nextPc;

	assign pcIdx   = IMEM_AW'((pc >> 2) % IMEM_WORDS);
	assign loadIdx = IMEM_AW'(loadAddr % IMEM_WORDS);
	assign instr   = imem[pcIdx];
	assign pcPlus4 = pc + 32'd4;

	// no delay slot, branch offset counts from pc+4
	always_comb
	begin
		case (jump)
			mipsCorePkg::JMP_TARGET: nextPc = {pcPlus4[31:28], target26, 2'b00};
			mipsCorePkg::JMP_REG:    nextPc = rsValue;
			default:
			begin
				if (takeBranch)
					nextPc = pcPlus4 + (immExt << 2);
				else
					nextPc = pcPlus4;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (loadEn)
			imem[loadIdx] <= loadData; // one word per cycle
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= '0;
		else if (advance)
			pc <= nextPc;
	end

	// jr takes its target from a register, so this covers the program too
	pcAligned: assert property (@(posedge clk) disable iff (rst)
		advance |=> pc[1:0] == 2'b00)
		else $error("pc left word alignment");

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic   clk,
	input logic   rst,
	regFileIf.regs rf
);

	mipsCorePkg::wordT regs [32];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (rf.wrEn && (rf.wrAddr != '0))
		begin
			regs[rf.wrAddr] <= rf.wrData; // r0 writes dropped here
		end
	end

	// read ports are combinational
	always_comb
	begin
		rf.rsData = (rf.rsAddr == '0) ? '0 : regs[rf.rsAddr];
		rf.rtData = (rf.rtAddr == '0) ? '0 : regs[rf.rtAddr];
	end

	// destination comes from the decoder mux in the core
	wrAddrKnown: assert property (@(posedge clk) disable iff (rst)
		rf.wrEn |-> !$isunknown(rf.wrAddr))
		else $error("register write with unknown address");

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
	input  mipsCorePkg::aluOpT aluOp,
	input  mipsIsaPkg::functT  funct,
	input  mipsCorePkg::wordT  a,
	input  mipsCorePkg::wordT  b,
	output mipsCorePkg::wordT  result,
	output logic               cond
);

	always_comb
	begin
		result = '0;
		cond   = 1'b0;
		case (aluOp)
			mipsCorePkg::ALU_FUNCT:
			begin
				case (funct)
					mipsIsaPkg::FN_ADD: result = a + b;
					mipsIsaPkg::FN_SUB: result = a - b;
					mipsIsaPkg::FN_AND: result = a & b;
					mipsIsaPkg::FN_OR:  result = a | b;
					mipsIsaPkg::FN_SLT: result = mipsCorePkg::wordT'($signed(a) < $signed(b));
					default:            result = '0;
				endcase
			end
			mipsCorePkg::ALU_ADD: result = a + b;
			mipsCorePkg::ALU_AND: result = a & b;
			mipsCorePkg::ALU_OR:  result = a | b;
			mipsCorePkg::ALU_SLT: result = mipsCorePkg::wordT'($signed(a) < $signed(b));
			mipsCorePkg::ALU_BEQ:
			begin
				result = a - b;
				cond   = (a == b);
			end
			mipsCorePkg::ALU_BNE:
			begin
				result = a - b;
				cond   = (a != b);
			end
			default: result = '0; // ALU_NONE
		endcase
	end

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  mipsIsaPkg::opcodeT    opcode,
	input  mipsIsaPkg::functT     funct,
	output mipsCorePkg::ctrlWordT ctrl
);

	always_comb
	begin
		// R format is the starting point
		ctrl.regDst   = mipsCorePkg::RD_RD;
		ctrl.jump     = mipsCorePkg::JMP_SEQ;
		ctrl.branch   = 1'b0;
		ctrl.memRead  = 1'b0;
		ctrl.memToReg = mipsCorePkg::WB_ALU;
		ctrl.aluOp    = mipsCorePkg::ALU_FUNCT;
		ctrl.memWrite = 1'b0;
		ctrl.aluSrc   = 1'b0;
		ctrl.zeroExt  = 1'b0;
		ctrl.regWrite = 1'b1;

		case (opcode)
			mipsIsaPkg::OP_RTYPE:
			begin
				if (funct == mipsIsaPkg::FN_JR)
				begin
					ctrl.jump     = mipsCorePkg::JMP_REG;
					ctrl.aluOp    = mipsCorePkg::ALU_NONE;
					ctrl.regWrite = 1'b0;
				end
			end
			mipsIsaPkg::OP_J:
			begin
				ctrl.jump     = mipsCorePkg::JMP_TARGET;
				ctrl.aluOp    = mipsCorePkg::ALU_NONE;
				ctrl.regWrite = 1'b0;
			end
			mipsIsaPkg::OP_JAL:
			begin
				ctrl.regDst   = mipsCorePkg::RD_RA; // link into r31
				ctrl.jump     = mipsCorePkg::JMP_TARGET;
				ctrl.memToReg = mipsCorePkg::WB_PC4;
				ctrl.aluOp    = mipsCorePkg::ALU_NONE;
			end
			mipsIsaPkg::OP_ADDI:
			begin
				ctrl.regDst = mipsCorePkg::RD_RT;
				ctrl.aluOp  = mipsCorePkg::ALU_ADD;
				ctrl.aluSrc = 1'b1;
			end
			mipsIsaPkg::OP_ANDI, mipsIsaPkg::OP_ORI:
			begin
				ctrl.regDst  = mipsCorePkg::RD_RT;
				ctrl.aluOp   = (opcode == mipsIsaPkg::OP_ANDI) ? mipsCorePkg::ALU_AND
				                                               : mipsCorePkg::ALU_OR;
				ctrl.aluSrc  = 1'b1;
				ctrl.zeroExt = 1'b1;
			end
			mipsIsaPkg::OP_SLTI:
			begin
				ctrl.regDst = mipsCorePkg::RD_RT;
				ctrl.aluOp  = mipsCorePkg::ALU_SLT;
				ctrl.aluSrc = 1'b1;
			end
			mipsIsaPkg::OP_BEQ, mipsIsaPkg::OP_BNE:
			begin
				ctrl.branch   = 1'b1;
				ctrl.aluOp    = (opcode == mipsIsaPkg::OP_BEQ) ? mipsCorePkg::ALU_BEQ
				                                               : mipsCorePkg::ALU_BNE;
				ctrl.regWrite = 1'b0;
			end
			mipsIsaPkg::OP_LW:
			begin
				ctrl.regDst   = mipsCorePkg::RD_RT;
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = mipsCorePkg::WB_MEM;
				ctrl.aluOp    = mipsCorePkg::ALU_ADD; // base plus offset
				ctrl.aluSrc   = 1'b1;
			end
			mipsIsaPkg::OP_SW:
			begin
				ctrl.aluOp    = mipsCorePkg::ALU_ADD;
				ctrl.aluSrc   = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.regWrite = 1'b0;
			end
			default:
			begin
				// unknown opcode just falls through with no side effects
				ctrl.aluOp    = mipsCorePkg::ALU_NONE;
				ctrl.regWrite = 1'b0;
				ctrl.memWrite = 1'b0;
			end
		endcase

		assert (!(ctrl.memRead && ctrl.memWrite))
			else $error("decoder asserted memRead and memWrite together");
	end

endmodule

//--- logic/regFileIf.sv
`timescale 1ns/1ps

interface regFileIf;

	mipsCorePkg::regAddrT rsAddr;
	mipsCorePkg::regAddrT rtAddr;
	mipsCorePkg::wordT    rsData;
	mipsCorePkg::wordT    rtData;
	logic                 wrEn;
	mipsCorePkg::regAddrT wrAddr;
	mipsCorePkg::wordT    wrData;

	// datapath side
	modport core (output rsAddr, rtAddr, wrEn, wrAddr, wrData, input rsData, rtData);

	// storage side
	modport regs (input rsAddr, rtAddr, wrEn, wrAddr, wrData, output rsData, rtData);

endinterface

//--- logic/mipsCorePkg.sv
package mipsCorePkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0]  regAddrT;

	// operation class handed from the decoder to the alu
	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_FUNCT = 3'd1, // alu looks at funct itself
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_BEQ   = 3'd4,
		ALU_BNE   = 3'd5,
		ALU_SLT   = 3'd6,
		ALU_NONE  = 3'd7
	} aluOpT;

	typedef enum logic [1:0] {RD_RT = 2'd0, RD_RD = 2'd1, RD_RA = 2'd2} regDstT;

	typedef enum logic [1:0] {JMP_SEQ = 2'd0, JMP_TARGET = 2'd1, JMP_REG = 2'd2} jumpT;

	typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MEM = 2'd1, WB_PC4 = 2'd2} memToRegT;

	typedef struct packed {
		regDstT   regDst;
		jumpT     jump;
		logic     branch;
		logic     memRead;
		memToRegT memToReg;
		aluOpT    aluOp;
		logic     memWrite;
		logic     aluSrc;   // immediate as operand b
		logic     zeroExt;  // andi/ori style immediate
		logic     regWrite;
	} ctrlWordT;

endpackage

//--- logic/mipsIsaPkg.sv
package mipsIsaPkg;

	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	// major opcodes
	localparam opcodeT OP_RTYPE = 6'b000000;
	localparam opcodeT OP_J     = 6'b000010;
	localparam opcodeT OP_JAL   = 6'b000011;
	localparam opcodeT OP_BEQ   = 6'b000100;
	localparam opcodeT OP_BNE   = 6'b000101;
	localparam opcodeT OP_ADDI  = 6'b001000;
	localparam opcodeT OP_SLTI  = 6'b001010;
	localparam opcodeT OP_ANDI  = 6'b001100;
	localparam opcodeT OP_ORI   = 6'b001101;
	localparam opcodeT OP_LW    = 6'b100011;
	localparam opcodeT OP_SW    = 6'b101011;

	// funct codes under OP_RTYPE
	localparam functT FN_JR  = 6'b001000;
	localparam functT FN_ADD = 6'b100000;
	localparam functT FN_SUB = 6'b100010;
	localparam functT FN_AND = 6'b100100;
	localparam functT FN_OR  = 6'b100101;
	localparam functT FN_SLT = 6'b101010;

	// bit positions inside the instruction word
	localparam int OP_MSB  = 31;
	localparam int OP_LSB  = 26;
	localparam int RS_MSB  = 25;
	localparam int RS_LSB  = 21;
	localparam int RT_MSB  = 20;
	localparam int RT_LSB  = 16;
	localparam int RD_MSB  = 15;
	localparam int RD_LSB  = 11;
	localparam int FN_MSB  = 5;
	localparam int FN_LSB  = 0;
	localparam int IMM_MSB = 15;
	localparam int IMM_LSB = 0;
	localparam int TGT_MSB = 25;
	localparam int TGT_LSB = 0;

endpackage
